/* verilog/pat_pkg.sv */
`default_nettype none

package pat_pkg;

	// ====================
	// widths and sizes
	// ====================
	localparam int I_W = 20; // instruction word
	localparam int I_ADR_W = 10; // 1024 instruction words
	localparam int D_W = 8; // accumulator and field byte
	localparam int DMEM_DEPTH = 16;
	localparam int DMEM_ADR_W = 4; // low bits of imm8
	localparam int FIELDP_W = 5;
	localparam int BUFP_W = 3;
	localparam int FIELD_LATENCY = 4; // field read to field write, in cycles

	// ====================
	// opcodes
	// ====================
	// i8 format
	localparam logic [3:0] OPC_OR = 4'd0;
	localparam logic [3:0] OPC_AND = 4'd1;
	localparam logic [3:0] OPC_ADDM = 4'd2;
	localparam logic [3:0] OPC_SUBM = 4'd3;
	localparam logic [3:0] OPC_ADD = 4'd4;
	localparam logic [3:0] OPC_SUB = 4'd5;
	localparam logic [3:0] OPC_LDI = 4'd6;
	localparam logic [3:0] OPC_LDM = 4'd7;
	localparam logic [3:0] OPC_BF = 4'd8; // signed relative branch
	localparam logic [3:0] OPC_STM = 4'd11;
	localparam logic [3:0] OPC_ORM = 4'd13;
	localparam logic [3:0] OPC_ANDM = 4'd14;
	localparam logic [3:0] OPC_PREFIX = 4'd15; // escapes to the next format
	// i3 format
	localparam logic [3:0] OPC_SHL = 4'd0;
	localparam logic [3:0] OPC_SHLO = 4'd1;
	localparam logic [3:0] OPC_SHR = 4'd2;
	localparam logic [3:0] OPC_ASR = 4'd3;
	localparam logic [3:0] OPC_IN = 4'd5;
	localparam logic [3:0] OPC_OUT = 4'd8;
	localparam logic [3:0] OPC_SETB = 4'd9;
	// i0 format
	localparam logic [3:0] OPC_NOT = 4'd0;
	localparam logic [3:0] OPC_MOV = 4'd1; // direction set by field_op
	localparam logic [3:0] OPC_NOP = 4'd15;

	localparam logic [I_W-1:0] INSTR_NOP = {8'h00, OPC_PREFIX, OPC_PREFIX, OPC_NOP};

	// alu codes, nine ops need a 4 bit code
	localparam int ALU_W = 4;
	localparam logic [ALU_W-1:0] ALU_OR = 4'd0;
	localparam logic [ALU_W-1:0] ALU_AND = 4'd1;
	localparam logic [ALU_W-1:0] ALU_NOT = 4'd2;
	localparam logic [ALU_W-1:0] ALU_ADD = 4'd3;
	localparam logic [ALU_W-1:0] ALU_SUB = 4'd4;
	localparam logic [ALU_W-1:0] ALU_SHL = 4'd5;
	localparam logic [ALU_W-1:0] ALU_SHLO = 4'd6; // shift left, fill with ones
	localparam logic [ALU_W-1:0] ALU_SHR = 4'd7;
	localparam logic [ALU_W-1:0] ALU_ASR = 4'd8;

	// ====================
	// instruction word
	// ====================
	typedef union packed {
		struct packed {
			logic [FIELDP_W-1:0] fieldp_next;
			logic [1:0] cond; // carried, not evaluated
			logic field_op; // 1 selects the field instead of acc
			logic [3:0] opcode_i8;
			logic [7:0] imm8;
		} long_v;
		struct packed {
			logic [FIELDP_W-1:0] fieldp_next;
			logic [1:0] cond;
			logic field_op;
			logic [3:0] prefix; // OPC_PREFIX for i3 and i0
			logic [3:0] opcode_i3;
			logic [3:0] opcode_i0; // low 3 bits double as i3 immediate
		} short_v;
	} instr_u;

	// decode to execute stage register
	typedef struct packed {
		logic [ALU_W-1:0] alu_op;
		logic [D_W-1:0] operand_b; // immediate or memory data
		logic field_op;
		logic dest_acc;
		logic dest_field;
		logic dest_dmem;
		logic src_imm; // result is operand_b itself
		logic src_in; // result is the input port
		logic is_mov;
		logic is_out;
		logic is_setb;
		logic [DMEM_ADR_W-1:0] dmem_adr;
	} exec_ctrl_t;

endpackage

`default_nettype wire

/* verilog/pat_program_counter.sv */
`default_nettype none

module pat_program_counter
	import pat_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire i_jump,
	input wire [D_W-1:0] i_offset, // signed
	output logic [I_ADR_W-1:0] o_pc
);

	logic [I_ADR_W-1:0] target;

	// o_pc is already one past the branch when bf sits in decode
	assign target = o_pc + {{(I_ADR_W-D_W){i_offset[D_W-1]}}, i_offset};

	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0; // held at 0 during program load
		else if (i_jump)
			o_pc <= target;
		else
			o_pc <= o_pc + 1'b1;
	end

endmodule

`default_nettype wire

/* verilog/pat_fetch.sv */
`default_nettype none

module pat_fetch
	import pat_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire [I_ADR_W-1:0] i_pc,
	input wire i_jump,
	input wire i_imem_write, // load port, used while reset is held
	input wire [I_ADR_W-1:0] i_imem_adr,
	input wire instr_u i_imem_data,
	output instr_u o_instr
);

	instr_u imem [2**I_ADR_W]; // one word per address

	// ====================
	// instruction memory
	// ====================
	always_ff @(posedge clk)
	begin
		if (i_imem_write)
			imem[i_imem_adr] <= i_imem_data;
	end

	// ====================
	// fetch register
	// ====================
	// the word behind a taken bf was fetched from the wrong address,
	// so it is replaced by a nop bubble
	always_ff @(posedge clk)
	begin
		if (reset || i_jump)
			o_instr <= INSTR_NOP;
		else
			o_instr <= imem[i_pc]; // asynchronous read, registered here
	end

endmodule

`default_nettype wire

/* verilog/pat_decoder.sv */
`default_nettype none

module pat_decoder
	import pat_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire instr_u i_instr,
	input wire [D_W-1:0] i_dmem_rdata,
	output logic [DMEM_ADR_W-1:0] o_dmem_radr,
	output logic o_jump,
	output logic [D_W-1:0] o_offset,
	output exec_ctrl_t o_ctrl,
	output logic [FIELDP_W-1:0] o_fieldp,
	output logic [FIELDP_W-1:0] o_fieldwp
);

	logic [3:0] opc8;
	logic [3:0] opc3;
	logic [3:0] opc0;
	logic is_i8;
	logic is_i3;
	logic is_i0;
	logic mem_src; // operand_b comes from data memory
	logic dest_reg; // result goes to acc or field
	logic [D_W-1:0] imm;
	exec_ctrl_t ctrl_d;
	logic [FIELD_LATENCY-1:0][FIELDP_W-1:0] fieldp_hist; // [0] is the newest

	assign opc8 = i_instr.long_v.opcode_i8;
	assign opc3 = i_instr.short_v.opcode_i3;
	assign opc0 = i_instr.short_v.opcode_i0;

	// format from the prefix chain
	assign is_i8 = (opc8 != OPC_PREFIX);
	assign is_i3 = !is_i8 && (opc3 != OPC_PREFIX);
	assign is_i0 = !is_i8 && !is_i3;

	assign imm = is_i8 ? i_instr.long_v.imm8 : {{(D_W-3){1'b0}}, opc0[2:0]};
	assign mem_src = is_i8 && (opc8 inside {OPC_ADDM, OPC_SUBM, OPC_LDM, OPC_ORM, OPC_ANDM});
	assign o_dmem_radr = i_instr.long_v.imm8[DMEM_ADR_W-1:0]; // read in this stage
	assign o_jump = is_i8 && (opc8 == OPC_BF);
	assign o_offset = i_instr.long_v.imm8;
	assign o_fieldwp = fieldp_hist[FIELD_LATENCY-1];

	// ====================
	// decode
	// ====================
	always_comb
	begin
		ctrl_d = '0;
		ctrl_d.alu_op = ALU_OR;
		if (is_i8)
		begin
			case (opc8)
				OPC_AND, OPC_ANDM: ctrl_d.alu_op = ALU_AND;
				OPC_ADD, OPC_ADDM: ctrl_d.alu_op = ALU_ADD;
				OPC_SUB, OPC_SUBM: ctrl_d.alu_op = ALU_SUB;
				default: ctrl_d.alu_op = ALU_OR;
			endcase
		end
		else if (is_i3)
		begin
			case (opc3)
				OPC_SHL: ctrl_d.alu_op = ALU_SHL;
				OPC_SHLO: ctrl_d.alu_op = ALU_SHLO;
				OPC_SHR: ctrl_d.alu_op = ALU_SHR;
				OPC_ASR: ctrl_d.alu_op = ALU_ASR;
				default: ctrl_d.alu_op = ALU_OR;
			endcase
		end
		else
			ctrl_d.alu_op = ALU_NOT; // only i0 alu op
		ctrl_d.operand_b = mem_src ? i_dmem_rdata : imm;
		ctrl_d.field_op = i_instr.long_v.field_op;
		ctrl_d.src_imm = is_i8 && (opc8 inside {OPC_LDI, OPC_LDM});
		ctrl_d.src_in = is_i3 && (opc3 == OPC_IN);
		ctrl_d.is_mov = is_i0 && (opc0 == OPC_MOV);
		ctrl_d.is_out = is_i3 && (opc3 == OPC_OUT);
		ctrl_d.is_setb = is_i3 && (opc3 == OPC_SETB);
		ctrl_d.dest_dmem = is_i8 && (opc8 == OPC_STM);
		ctrl_d.dmem_adr = i_instr.long_v.imm8[DMEM_ADR_W-1:0];
		dest_reg = (is_i8 && (opc8 inside {OPC_OR, OPC_AND, OPC_ADD, OPC_SUB}))
			|| mem_src || ctrl_d.src_imm || ctrl_d.src_in || ctrl_d.is_mov
			|| (is_i3 && (opc3 inside {OPC_SHL, OPC_SHLO, OPC_SHR, OPC_ASR}))
			|| (is_i0 && (opc0 == OPC_NOT));
		ctrl_d.dest_acc = dest_reg && !ctrl_d.field_op;
		ctrl_d.dest_field = dest_reg && ctrl_d.field_op;
	end

	// ====================
	// stage register
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_ctrl <= '0;
			o_fieldp <= '0;
			fieldp_hist <= '0;
		end
		else
		begin
			o_ctrl <= ctrl_d;
			o_fieldp <= i_instr.long_v.fieldp_next; // every word, nop included
			fieldp_hist <= {fieldp_hist[FIELD_LATENCY-2:0], o_fieldp};
		end
	end

endmodule

`default_nettype wire

/* verilog/pat_data_mem.sv */
`default_nettype none

module pat_data_mem
	import pat_pkg::*;
(
	input wire clk,
	input wire [DMEM_ADR_W-1:0] i_radr,
	input wire i_wen,
	input wire [DMEM_ADR_W-1:0] i_wadr,
	input wire [D_W-1:0] i_wdata,
	output logic [D_W-1:0] o_rdata
);

	logic [D_W-1:0] mem [DMEM_DEPTH];

	assign o_rdata = mem[i_radr]; // no bypass, a write shows up next cycle

	always_ff @(posedge clk)
	begin
		if (i_wen)
			mem[i_wadr] <= i_wdata;
	end

endmodule

`default_nettype wire

/* verilog/pat_alu.sv */
`default_nettype none

module pat_alu
	import pat_pkg::*;
(
	input wire [D_W-1:0] i_a,
	input wire [D_W-1:0] i_b,
	input wire [ALU_W-1:0] i_op,
	output logic [D_W-1:0] o_y
);

	logic [2:0] sh; // shift count
	logic [D_W-1:0] fill; // low sh bits set, for shlo

	assign sh = i_b[2:0];
	assign fill = ~({D_W{1'b1}} << sh);

	always_comb
	begin
		case (i_op)
			ALU_OR: o_y = i_a | i_b;
			ALU_AND: o_y = i_a & i_b;
			ALU_NOT: o_y = ~i_a; // i_b unused
			ALU_ADD: o_y = i_a + i_b; // carry dropped
			ALU_SUB: o_y = i_a - i_b;
			ALU_SHL: o_y = i_a << sh;
			ALU_SHLO: o_y = (i_a << sh) | fill;
			ALU_SHR: o_y = i_a >> sh;
			ALU_ASR: o_y = $signed(i_a) >>> sh; // sign bit copied in
			default: o_y = i_a;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/pat_execute.sv */
`default_nettype none

module pat_execute
	import pat_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire exec_ctrl_t i_ctrl,
	input wire [D_W-1:0] i_field_in,
	input wire [D_W-1:0] i_inputs,
	output logic o_dmem_wen,
	output logic [DMEM_ADR_W-1:0] o_dmem_wadr,
	output logic [D_W-1:0] o_dmem_wdata,
	output logic [D_W-1:0] o_field_out,
	output logic o_field_write_en,
	output logic [D_W-1:0] o_outputs,
	output logic [BUFP_W-1:0] o_bufp
);

	logic [D_W-1:0] acc; // the accumulator
	logic [D_W-1:0] acc_alu_y;
	logic [D_W-1:0] field_alu_y;
	logic [D_W-1:0] acc_result;
	logic [D_W-1:0] field_result;

	// one alu per destination keeps the operand mux off the alu input
	pat_alu acc_alu_i (.i_a(acc), .i_b(i_ctrl.operand_b), .i_op(i_ctrl.alu_op), .o_y(acc_alu_y));
	pat_alu field_alu_i (
		.i_a(i_field_in),
		.i_b(i_ctrl.operand_b),
		.i_op(i_ctrl.alu_op),
		.o_y(field_alu_y)
	);

	assign acc_result = i_ctrl.is_mov ? i_field_in : // field to acc
		i_ctrl.src_imm ? i_ctrl.operand_b :
		i_ctrl.src_in ? i_inputs : acc_alu_y;
	assign field_result = i_ctrl.is_mov ? acc : // acc to field
		i_ctrl.src_imm ? i_ctrl.operand_b :
		i_ctrl.src_in ? i_inputs : field_alu_y;

	// store goes straight to the memory, written at the commit edge
	assign o_dmem_wen = i_ctrl.dest_dmem;
	assign o_dmem_wadr = i_ctrl.dmem_adr;
	assign o_dmem_wdata = i_ctrl.field_op ? i_field_in : acc;

	// ====================
	// commit
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			o_field_write_en <= 1'b0;
			o_outputs <= '0;
			o_bufp <= '0;
		end
		else
		begin
			if (i_ctrl.dest_acc)
				acc <= acc_result;
			o_field_write_en <= i_ctrl.dest_field; // one pulse per field result
			if (i_ctrl.is_out)
				o_outputs <= acc;
			if (i_ctrl.is_setb)
				o_bufp <= i_ctrl.operand_b[BUFP_W-1:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_ctrl.dest_field)
			o_field_out <= field_result; // valid with o_field_write_en
	end

endmodule

`default_nettype wire

/* verilog/pat_top.sv */
`default_nettype none

module pat_top
	import pat_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire i_imem_write,
	input wire [I_ADR_W-1:0] i_imem_adr,
	input wire instr_u i_imem_data,
	input wire [D_W-1:0] i_field_in,
	input wire [D_W-1:0] i_inputs,
	output logic [I_ADR_W-1:0] o_pc,
	output logic o_jump,
	output logic [BUFP_W-1:0] o_bufp,
	output logic [FIELDP_W-1:0] o_fieldp,
	output logic [FIELDP_W-1:0] o_fieldwp,
	output logic [D_W-1:0] o_field_out,
	output logic o_field_write_en,
	output logic [D_W-1:0] o_outputs
);

	instr_u instr; // fetch to decode
	logic [D_W-1:0] offset; // bf displacement
	exec_ctrl_t ctrl; // decode to execute
	logic [DMEM_ADR_W-1:0] dmem_radr;
	logic [D_W-1:0] dmem_rdata;
	logic dmem_wen;
	logic [DMEM_ADR_W-1:0] dmem_wadr;
	logic [D_W-1:0] dmem_wdata;

	pat_program_counter pc_i (.clk, .reset, .i_jump(o_jump), .i_offset(offset), .o_pc);

	pat_fetch fetch_i (
		.clk, .reset, .i_pc(o_pc), .i_jump(o_jump),
		.i_imem_write, .i_imem_adr, .i_imem_data, .o_instr(instr)
	);

	pat_decoder decoder_i (
		.clk, .reset, .i_instr(instr), .i_dmem_rdata(dmem_rdata), .o_dmem_radr(dmem_radr),
		.o_jump, .o_offset(offset), .o_ctrl(ctrl), .o_fieldp, .o_fieldwp
	);

	pat_data_mem dmem_i (
		.clk, .i_radr(dmem_radr), .i_wen(dmem_wen), .i_wadr(dmem_wadr),
		.i_wdata(dmem_wdata), .o_rdata(dmem_rdata)
	);

	pat_execute execute_i (
		.clk, .reset, .i_ctrl(ctrl), .i_field_in, .i_inputs,
		.o_dmem_wen(dmem_wen), .o_dmem_wadr(dmem_wadr), .o_dmem_wdata(dmem_wdata),
		.o_field_out, .o_field_write_en, .o_outputs, .o_bufp
	);

endmodule

`default_nettype wire

/* bench/pat_tb_model.svh */
`ifndef PAT_TB_MODEL_SVH
`define PAT_TB_MODEL_SVH

// ====================
// random numbers
// ====================
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // galois, taps 16 14 13 11
endfunction

function automatic logic [7:0] take_bits(input int n);
	logic [7:0] v;
	int i;
	v = '0;
	for (i = 0; i < n; i++)
	begin
		v = {v[6:0], lfsr_state[0]}; // one step per bit
		lfsr_state = lfsr_next(lfsr_state);
	end
	return v;
endfunction

// ====================
// encoders
// ====================
// top 7 bits (fieldp_next and cond) are random on every word
function automatic logic [I_W-1:0] enc_i8(input logic fo, input logic [3:0] opc,
	input logic [7:0] imm);
	logic [7:0] top;
	top = take_bits(7);
	return {top[6:0], fo, opc, imm};
endfunction

function automatic logic [I_W-1:0] enc_i3(input logic fo, input logic [3:0] opc,
	input logic [2:0] imm);
	logic [7:0] top;
	top = take_bits(7);
	return {top[6:0], fo, 4'hF, opc, 1'b0, imm};
endfunction

function automatic logic [I_W-1:0] enc_i0(input logic fo, input logic [3:0] opc);
	logic [7:0] top;
	top = take_bits(7);
	return {top[6:0], fo, 4'hF, 4'hF, opc};
endfunction

// ====================
// checks
// ====================
task automatic fail_run(input string why);
	$display("%s", why);
	$display("Checks failed");
	$fatal(1, "run stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] got,
	input logic [31:0] exp);
	if (got !== exp)
		fail_run($sformatf("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp));
endtask

// ====================
// reference model
// ====================
// runs prog in program order, fills exp_out and exp_field, returns the final bufp
function automatic logic [BUFP_W-1:0] model_program(input logic [D_W-1:0] fin,
	input logic [D_W-1:0] inp);
	logic [I_W-1:0] w;
	logic [I_ADR_W-1:0] pc_m;
	logic [I_ADR_W-1:0] next_pc;
	logic [D_W-1:0] acc;
	logic [D_W-1:0] src;
	logic [D_W-1:0] r;
	logic [D_W-1:0] m;
	logic [D_W-1:0] shown; // what o_outputs holds now
	logic [BUFP_W-1:0] bufp_m;
	logic [2:0] s;
	logic fo;
	logic has_r;
	acc = '0;
	shown = '0;
	bufp_m = '0;
	pc_m = '0;
	exp_out.delete();
	exp_field.delete();
	repeat (256)
	begin
		w = prog[pc_m];
		fo = w[12];
		s = w[2:0];
		m = model_dmem[w[3:0]];
		src = fo ? fin : acc; // field byte is operand a under field_op
		next_pc = pc_m + 1'b1;
		has_r = 1'b1;
		r = '0;
		if (w[11:8] != OPC_PREFIX)
		begin
			case (w[11:8])
				OPC_OR: r = src | w[7:0];
				OPC_AND: r = src & w[7:0];
				OPC_ADD: r = src + w[7:0];
				OPC_SUB: r = src - w[7:0];
				OPC_LDI: r = w[7:0];
				OPC_LDM: r = m;
				OPC_ADDM: r = src + m;
				OPC_SUBM: r = src - m;
				OPC_ORM: r = src | m;
				OPC_ANDM: r = src & m;
				OPC_STM:
				begin
					model_dmem[w[3:0]] = fo ? fin : acc;
					has_r = 1'b0;
				end
				OPC_BF:
				begin
					if (w[7:0] == 8'hFF)
						return bufp_m; // branch to itself, program done
					next_pc = next_pc + {{(I_ADR_W-8){w[7]}}, w[7:0]};
					has_r = 1'b0;
				end
				default: has_r = 1'b0;
			endcase
		end
		else if (w[7:4] != OPC_PREFIX)
		begin
			case (w[7:4])
				OPC_SHL: r = src << s;
				OPC_SHLO: r = (src << s) | ((8'd1 << s) - 8'd1); // ones shifted in
				OPC_SHR: r = src >> s;
				OPC_ASR: r = (src >> s) | (src[7] ? ~(8'hFF >> s) : 8'h00);
				OPC_IN: r = inp;
				OPC_OUT:
				begin
					if (acc != shown)
						exp_out.push_back(acc); // only changes are visible
					shown = acc;
					has_r = 1'b0;
				end
				OPC_SETB:
				begin
					bufp_m = s;
					has_r = 1'b0;
				end
				default: has_r = 1'b0;
			endcase
		end
		else
		begin
			case (w[3:0])
				OPC_NOT: r = ~src;
				OPC_MOV: r = fo ? acc : fin; // direction by field_op
				default: has_r = 1'b0;
			endcase
		end
		if (has_r && fo)
			exp_field.push_back(r);
		else if (has_r)
			acc = r;
		pc_m = next_pc;
	end
	return bufp_m;
endfunction

`endif

/* bench/pat_tb.sv */
`default_nettype none

module pat_tb
	import pat_pkg::*;
();

	localparam int NUM_PROGS = 24;
	localparam int TIMEOUT_CYCLES = NUM_PROGS * 64;
	localparam int RESET_CYCLES = 5;

	logic clk = 1'b0;
	logic reset;
	logic imem_write;
	logic [I_ADR_W-1:0] imem_adr;
	logic [I_W-1:0] imem_data;
	logic [D_W-1:0] field_in;
	logic [D_W-1:0] inputs;
	logic [I_ADR_W-1:0] pc;
	logic jump;
	logic [BUFP_W-1:0] bufp;
	logic [FIELDP_W-1:0] fieldp;
	logic [FIELDP_W-1:0] fieldwp;
	logic [D_W-1:0] field_out;
	logic field_write_en;
	logic [D_W-1:0] outputs;

	logic [15:0] lfsr_state = 16'd96;
	logic [I_W-1:0] prog[$]; // current program
	logic [D_W-1:0] exp_out[$];
	logic [D_W-1:0] exp_field[$];
	logic [D_W-1:0] model_dmem [DMEM_DEPTH]; // persists like the real memory
	logic [BUFP_W-1:0] exp_bufp;
	logic [D_W-1:0] field_v;
	logic [D_W-1:0] inputs_v;
	logic running = 1'b0; // a program is executing
	logic reset_at_edge = 1'b1; // reset as seen at the last rising edge
	logic [FIELDP_W-1:0] fp_hist [FIELD_LATENCY]; // [0] is the last sample
	logic [D_W-1:0] last_out;
	int field_idx;
	int out_idx;
	int cycles = 0;

	`include "pat_tb_model.svh"

	pat_top pat_top_i (
		.clk, .reset, .i_imem_write(imem_write), .i_imem_adr(imem_adr),
		.i_imem_data(imem_data), .i_field_in(field_in), .i_inputs(inputs),
		.o_pc(pc), .o_jump(jump), .o_bufp(bufp), .o_fieldp(fieldp), .o_fieldwp(fieldwp),
		.o_field_out(field_out), .o_field_write_en(field_write_en), .o_outputs(outputs)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		reset_at_edge <= reset;
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			fail_run($sformatf("timeout after %0d cycles, a program never reached its end", cycles));
	end

	// ====================
	// compare process
	// ====================
	always @(negedge clk)
	begin : compare
		int j;
		if (reset_at_edge)
		begin
			for (j = 0; j < FIELD_LATENCY; j++)
				fp_hist[j] = '0; // reset clears the write pointer history
		end
		check_value("o_fieldwp", fieldwp, fp_hist[FIELD_LATENCY-1]);
		for (j = FIELD_LATENCY-1; j > 0; j--)
			fp_hist[j] = fp_hist[j-1];
		fp_hist[0] = fieldp;
		if (running && field_write_en)
		begin
			if (field_idx >= exp_field.size())
				fail_run($sformatf("field write at %0t that the model does not expect", $time));
			else
				check_value("o_field_out", field_out, exp_field[field_idx]);
			field_idx++;
		end
		if (running && (outputs !== last_out))
		begin
			if (out_idx >= exp_out.size())
				fail_run($sformatf("o_outputs changed at %0t more often than expected", $time));
			else
				check_value("o_outputs", outputs, exp_out[out_idx]);
			out_idx++;
			last_out = outputs;
		end
	end

	// ====================
	// program generation
	// ====================
	function automatic logic [I_W-1:0] random_reg_op(input logic fo);
		case (take_bits(4) % 11)
			0: return enc_i8(fo, OPC_OR, take_bits(8));
			1: return enc_i8(fo, OPC_AND, take_bits(8));
			2: return enc_i8(fo, OPC_ADD, take_bits(8));
			3: return enc_i8(fo, OPC_SUB, take_bits(8));
			4: return enc_i8(fo, OPC_LDI, take_bits(8));
			5: return enc_i3(fo, OPC_SHL, take_bits(3));
			6: return enc_i3(fo, OPC_SHLO, take_bits(3));
			7: return enc_i3(fo, OPC_SHR, take_bits(3));
			8: return enc_i3(fo, OPC_ASR, take_bits(3));
			9: return enc_i3(fo, OPC_IN, take_bits(3));
			default: return enc_i0(fo, OPC_NOT);
		endcase
	endfunction

	task automatic build_program(input int kind);
		int k;
		logic [7:0] hi;
		logic [7:0] adr;
		prog.delete();
		case (kind)
			0:
			begin // accumulator ops, each shown by out
				prog.push_back(enc_i8(0, OPC_LDI, take_bits(8)));
				for (k = 0; k < 8; k++)
				begin
					prog.push_back(random_reg_op(1'b0));
					prog.push_back(enc_i3(0, OPC_OUT, 3'd0));
				end
			end
			1:
			begin // stores first, one nop gap after each
				for (k = 0; k < 3; k++)
				begin
					hi = take_bits(4);
					prog.push_back(enc_i8(0, OPC_LDI, take_bits(8)));
					prog.push_back(enc_i8(0, OPC_STM, {hi[3:0], 4'(k)}));
					prog.push_back(enc_i0(0, OPC_NOP));
				end
				for (k = 0; k < 5; k++)
				begin
					hi = take_bits(4); // upper imm bits do not address
					adr = take_bits(2) % 3;
					case (take_bits(3) % 5)
						0: prog.push_back(enc_i8(0, OPC_LDM, {hi[3:0], adr[3:0]}));
						1: prog.push_back(enc_i8(0, OPC_ADDM, {hi[3:0], adr[3:0]}));
						2: prog.push_back(enc_i8(0, OPC_SUBM, {hi[3:0], adr[3:0]}));
						3: prog.push_back(enc_i8(0, OPC_ORM, {hi[3:0], adr[3:0]}));
						default: prog.push_back(enc_i8(0, OPC_ANDM, {hi[3:0], adr[3:0]}));
					endcase
					prog.push_back(enc_i3(0, OPC_OUT, 3'd0));
				end
			end
			2:
			begin // field ops, both movs, field store read back
				prog.push_back(enc_i8(0, OPC_LDI, take_bits(8)));
				for (k = 0; k < 6; k++)
				begin
					case (take_bits(2))
						0, 1: prog.push_back(random_reg_op(1'b1));
						2: prog.push_back(enc_i0(1, OPC_MOV)); // acc to field
						default:
						begin
							prog.push_back(enc_i0(0, OPC_MOV)); // field to acc
							prog.push_back(enc_i3(0, OPC_OUT, 3'd0));
						end
					endcase
				end
				prog.push_back(enc_i0(1, OPC_MOV));
				prog.push_back(enc_i0(0, OPC_MOV));
				prog.push_back(enc_i3(0, OPC_OUT, 3'd0));
				prog.push_back(enc_i8(1, OPC_STM, 8'h0F));
				prog.push_back(enc_i8(0, OPC_LDI, take_bits(8))); // gap before the load
				prog.push_back(enc_i3(0, OPC_OUT, 3'd0));
				prog.push_back(enc_i8(0, OPC_LDM, 8'h0F));
				prog.push_back(enc_i3(0, OPC_OUT, 3'd0));
			end
			default:
			begin // forward and backward branches, addresses 0 to 12
				prog.push_back(enc_i8(0, OPC_LDI, take_bits(8)));
				prog.push_back(enc_i8(0, OPC_BF, 8'h01)); // to 3
				prog.push_back(enc_i8(0, OPC_LDI, take_bits(8))); // skipped
				prog.push_back(enc_i3(0, OPC_OUT, 3'd0));
				prog.push_back(enc_i8(0, OPC_ADD, take_bits(8)));
				prog.push_back(enc_i8(0, OPC_BF, 8'h02)); // to 8
				prog.push_back(enc_i3(0, OPC_OUT, 3'd0));
				prog.push_back(enc_i8(0, OPC_BF, 8'h03)); // to 11
				prog.push_back(enc_i3(0, OPC_OUT, 3'd0));
				prog.push_back(enc_i8(0, OPC_ADD, take_bits(8)));
				prog.push_back(enc_i8(0, OPC_BF, 8'hFB)); // back to 6
				prog.push_back(enc_i3(0, OPC_SETB, take_bits(3)));
				prog.push_back(enc_i3(0, OPC_OUT, 3'd0));
			end
		endcase
		prog.push_back(enc_i8(0, OPC_BF, 8'hFF)); // branch to itself
	endtask

	task automatic check_after_reset();
		check_value("o_pc", pc, 0);
		check_value("o_jump", jump, 0);
		check_value("o_field_write_en", field_write_en, 0);
		check_value("o_outputs", outputs, 0);
		check_value("o_bufp", bufp, 0);
		check_value("o_fieldp", fieldp, 0);
		check_value("o_fieldwp", fieldwp, 0);
	endtask

	// ====================
	// main sequence
	// ====================
	initial
	begin
		reset = 1'b1;
		imem_write = 1'b0;
		imem_adr = '0;
		imem_data = INSTR_NOP;
		field_in = '0;
		inputs = '0;
		for (int p = 0; p < NUM_PROGS; p++)
		begin
			build_program(p % 4);
			field_v = take_bits(8);
			inputs_v = take_bits(8);
			exp_bufp = model_program(field_v, inputs_v);
			@(negedge clk);
			reset = 1'b1;
			for (int i = 0; i < prog.size(); i++)
			begin
				imem_write = 1'b1; // loaded while reset holds the pc
				imem_adr = i;
				imem_data = prog[i];
				@(negedge clk);
			end
			imem_write = 1'b0;
			repeat (RESET_CYCLES) @(negedge clk);
			check_after_reset();
			field_in = field_v;
			inputs = inputs_v;
			field_idx = 0;
			out_idx = 0;
			last_out = '0;
			reset = 1'b0;
			running = 1'b1;
			// final bf in decode, then its predecessor commits
			do
				@(negedge clk);
			while (!(jump && (pc == prog.size())));
			repeat (2) @(negedge clk);
			@(posedge clk);
			running = 1'b0;
			check_value("o_outputs update count", out_idx, exp_out.size());
			check_value("field write count", field_idx, exp_field.size());
			check_value("o_bufp", bufp, exp_bufp);
		end
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+bench
verilog/pat_pkg.sv
verilog/pat_program_counter.sv
verilog/pat_fetch.sv
verilog/pat_decoder.sv
verilog/pat_data_mem.sv
verilog/pat_alu.sv
verilog/pat_execute.sv
verilog/pat_top.sv
bench/pat_tb.sv

/* Bender.yml */
package:
  name: pat

sources:
  - files:
      - verilog/pat_pkg.sv
      - verilog/pat_program_counter.sv
      - verilog/pat_fetch.sv
      - verilog/pat_decoder.sv
      - verilog/pat_data_mem.sv
      - verilog/pat_alu.sv
      - verilog/pat_execute.sv
      - verilog/pat_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/pat_tb.sv
